/* Makefile */
TOP = tbLanzones

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -qF "** FAIL **" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "** PASS **" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* busCtrl.sv */
module busCtrl #(
   parameter lanzonesPkg::word_t resetPc = '0
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               run,
   input  lanzonesPkg::word_t rData,
   input  logic               vld,
   output logic               rdy,
   output lanzonesPkg::word_t addr,
   output logic               wEn,
   output lanzonesPkg::word_t wData,
   output lanzonesPkg::word_t instr,
   output logic               execStrobe,
   input  logic               isStore,
   input  lanzonesPkg::word_t storeAddr,
   input  lanzonesPkg::word_t storeData
);
   import lanzonesPkg::*;

   busState_e state;
   word_t     pc;
   word_t     stAddr;

   // port outputs follow the state so they hold while vld is low
   assign rdy        = (state == sFetch) || (state == sStore);
   assign wEn        = (state == sStore);
   assign addr       = (state == sStore) ? stAddr : pc;
   assign execStrobe = (state == sExec);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= sIdle;
         pc    <= resetPc;
         wData <= '0;
      end
      else begin
         case (state)
            sIdle: begin
               if (run) begin
                  state <= sFetch;
               end
            end
            sFetch: begin
               if (vld) begin
                  state <= sExec;
                  pc    <= pc + word_t'(1);
               end
            end
            sExec: begin
               if (isStore) begin
                  state <= sStore;
                  wData <= storeData;
               end
               else if (run) begin
                  state <= sFetch;
               end
               else begin
                  state <= sIdle;
               end
            end
            sStore: begin
               // one idle cycle so rdy drops before the next fetch
               if (vld) begin
                  state <= sIdle;
               end
            end
            default: begin
               state <= sIdle;
            end
         endcase
      end
   end

   // instruction and store address
   always_ff @(posedge clk) begin
      if (state == sFetch && vld) begin
         instr <= rData;
      end
      if (state == sExec && isStore) begin
         stAddr <= storeAddr;
      end
   end

endmodule

/* coreBus_checker.sv */
module coreBusChecker (
   input logic               clk,
   input logic               rstn,
   input logic               rdy,
   input logic               vld,
   input logic               wEn,
   input lanzonesPkg::word_t addr,
   input lanzonesPkg::word_t wData
);
   import lanzonesPkg::*;

   // port idle right after reset
   assert property (@(posedge clk) !rstn |=> (!rdy && !wEn))
      else $error("rdy or wEn high after reset");

   // back-pressure freezes the request
   assert property (@(posedge clk) disable iff (!rstn)
      (rdy && !vld) |=> ($stable(addr) && $stable(wEn) && $stable(wData)))
      else $error("port outputs changed while waiting for vld");

   assert property (@(posedge clk) disable iff (!rstn) wEn |-> rdy)
      else $error("wEn high without rdy");

endmodule

bind lanzonesCore coreBusChecker uChecker (
   .clk(clk),
   .rstn(rstn),
   .rdy(rdy),
   .vld(vld),
   .wEn(wEn),
   .addr(addr),
   .wData(wData)
);

/* execUnit.sv */
module execUnit (
   input  logic                 execStrobe,
   input  lanzonesPkg::opcode_e op,
   input  lanzonesPkg::regIdx_t rd,
   input  lanzonesPkg::word_t   imm,
   input  lanzonesPkg::word_t   rs1Data,
   input  lanzonesPkg::word_t   rs2Data,
   output logic                 regWEn,
   output lanzonesPkg::regIdx_t rdIdx,
   output lanzonesPkg::word_t   wbData,
   output logic                 isStore,
   output lanzonesPkg::word_t   storeAddr,
   output lanzonesPkg::word_t   storeData
);
   import lanzonesPkg::*;

   assign rdIdx = rd;

   // write-back only in the exec cycle
   always_comb begin
      regWEn = 1'b0;
      wbData = '0;
      case (op)
         opLui: begin
            regWEn = execStrobe;
            wbData = imm;
         end
         opAdd: begin
            regWEn = execStrobe;
            wbData = rs1Data + rs2Data;
         end
         default: begin
            regWEn = 1'b0;
         end
      endcase
   end

   // store target is a word index like fetch addresses
   assign isStore   = (op == opStore);
   assign storeAddr = rs1Data + imm;
   assign storeData = rs2Data;

endmodule

/* instDecode.sv */
module instDecode (
   input  lanzonesPkg::word_t   instr,
   output lanzonesPkg::opcode_e op,
   output lanzonesPkg::regIdx_t rd,
   output lanzonesPkg::regIdx_t rs1,
   output lanzonesPkg::regIdx_t rs2,
   output lanzonesPkg::word_t   imm
);
   import lanzonesPkg::*;

   logic [6:0] opField;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opField = instr[6:0];
   assign funct3  = instr[14:12];
   assign funct7  = instr[31:25];

   // register fields sit at fixed positions in every format
   assign rd  = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   always_comb begin
      op  = opNone;
      imm = '0;
      case (opField)
         opLui: begin
            op = opLui;
            // u-type, already shifted into place
            imm = {instr[31:12], 12'b0};
         end
         opAdd: begin
            // sub and the other alu ops stay no-ops
            if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
               op = opAdd;
            end
         end
         opStore: begin
            op = opStore;
            // s-type, sign extended
            imm = {{20{instr[31]}}, funct7, instr[11:7]};
         end
         default: begin
            op = opNone;
         end
      endcase
   end

endmodule

/* lanzonesCore.sv */
module lanzonesCore #(
   parameter lanzonesPkg::word_t resetPc = '0
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               run,
   output logic               rdy,
   output lanzonesPkg::word_t addr,
   output logic               wEn,
   output lanzonesPkg::word_t wData,
   input  lanzonesPkg::word_t rData,
   input  logic               vld
);
   import lanzonesPkg::*;

   word_t     instr;
   logic      execStrobe;
   opcode_e   op;
   regIdx_t   rd;
   regIdx_t   rs1;
   regIdx_t   rs2;
   word_t     imm;
   word_t     rs1Data;
   word_t     rs2Data;
   logic      regWEn;
   regIdx_t   rdIdx;
   word_t     wbData;
   logic      isStore;
   word_t     storeAddr;
   word_t     storeData;

   busCtrl #(
      .resetPc(resetPc)
   ) uBus (
      .clk(clk),
      .rstn(rstn),
      .run(run),
      .rData(rData),
      .vld(vld),
      .rdy(rdy),
      .addr(addr),
      .wEn(wEn),
      .wData(wData),
      .instr(instr),
      .execStrobe(execStrobe),
      .isStore(isStore),
      .storeAddr(storeAddr),
      .storeData(storeData)
   );

   // decode and register read run side by side on the held instruction
   instDecode uDec (
      .instr(instr),
      .op(op),
      .rd(rd),
      .rs1(rs1),
      .rs2(rs2),
      .imm(imm)
   );

   regFile uRegs (
      .clk(clk),
      .rstn(rstn),
      .rs1(rs1),
      .rs2(rs2),
      .rs1Data(rs1Data),
      .rs2Data(rs2Data),
      .regWEn(regWEn),
      .rdIdx(rdIdx),
      .wbData(wbData)
   );

   execUnit uExec (
      .execStrobe(execStrobe),
      .op(op),
      .rd(rd),
      .imm(imm),
      .rs1Data(rs1Data),
      .rs2Data(rs2Data),
      .regWEn(regWEn),
      .rdIdx(rdIdx),
      .wbData(wbData),
      .isStore(isStore),
      .storeAddr(storeAddr),
      .storeData(storeData)
   );

endmodule

/* lanzonesPkg.sv */
package lanzonesPkg;

   // one machine word
   localparam int dataWidth = 32;

   typedef logic [dataWidth-1:0] word_t;

   // x0..x31
   typedef logic [4:0] regIdx_t;

   // major opcodes at their RV32I encodings
   typedef enum logic [6:0] {
      opNone  = 7'b0000000,
      opStore = 7'b0100011,
      opAdd   = 7'b0110011,
      opLui   = 7'b0110111
   } opcode_e;

   // memory port sequencer
   typedef enum logic [1:0] {
      sIdle,
      sFetch,
      sExec,
      sStore
   } busState_e;

endpackage

/* regFile.sv */
module regFile (
   input  logic                 clk,
   input  logic                 rstn,
   input  lanzonesPkg::regIdx_t rs1,
   input  lanzonesPkg::regIdx_t rs2,
   output lanzonesPkg::word_t   rs1Data,
   output lanzonesPkg::word_t   rs2Data,
   input  logic                 regWEn,
   input  lanzonesPkg::regIdx_t rdIdx,
   input  lanzonesPkg::word_t   wbData
);
   import lanzonesPkg::*;

   word_t regs [32];

   // x0 always reads zero
   assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end
      else begin
         // writes to x0 are dropped
         if (regWEn && rdIdx != '0) begin
            regs[rdIdx] <= wbData;
         end
      end
   end

endmodule

/* tb.f */
lanzonesPkg.sv
instDecode.sv
regFile.sv
execUnit.sv
busCtrl.sv
lanzonesCore.sv
coreBus_checker.sv
tbLanzones.sv

/* tbLanzones.sv */
module tbLanzones;
   import lanzonesPkg::*;

   localparam int progLen = 16;
   localparam int maxDelay = 3;
   localparam int timeoutCycles = 60;

   logic  clk;
   logic  rstn;
   logic  run;
   logic  rdy;
   word_t addr;
   logic  wEn;
   word_t wData;
   word_t rData;
   logic  vld;

   integer seed;
   word_t  prog [progLen];

   // expected and observed transfers, wEn tells store from fetch
   logic  expWEn [$];
   word_t expAddr [$];
   word_t expData [$];
   logic  obsWEn [$];
   word_t obsAddr [$];
   word_t obsData [$];

   lanzonesCore #(
      .resetPc('0)
   ) UUT (
      .clk(clk),
      .rstn(rstn),
      .run(run),
      .rdy(rdy),
      .addr(addr),
      .wEn(wEn),
      .wData(wData),
      .rData(rData),
      .vld(vld)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic word_t encodeLui(input regIdx_t rd, input logic [19:0] upper);
      return {upper, rd, opLui};
   endfunction

   function automatic word_t encodeAdd(input regIdx_t rd, input regIdx_t rs1, input regIdx_t rs2);
      return {7'b0000000, rs2, rs1, 3'b000, rd, opAdd};
   endfunction

   function automatic word_t encodeSw(input regIdx_t rs2, input regIdx_t rs1,
                                      input logic [11:0] offset);
      return {offset[11:5], rs2, rs1, 3'b010, offset[4:0], opStore};
   endfunction

   function automatic word_t fetchWord(input word_t a);
      if (a < 32'd16) begin
         return prog[a[3:0]];
      end
      // past the program the core sees no-ops
      return '0;
   endfunction

   // instruction-set model of the program, one fetch per word plus its store
   function automatic void refModel();
      word_t x [32];
      word_t w;
      word_t sImm;
      for (int i = 0; i < 32; i++) begin
         x[i] = '0;
      end
      for (int pc = 0; pc < progLen; pc++) begin
         w = prog[pc];
         expWEn.push_back(1'b0);
         expAddr.push_back(word_t'(pc));
         expData.push_back('0);
         if (w[6:0] == 7'h37) begin
            if (w[11:7] != 5'd0) begin
               x[w[11:7]] = {w[31:12], 12'h000};
            end
         end
         else if (w[6:0] == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'b0000000) begin
            if (w[11:7] != 5'd0) begin
               x[w[11:7]] = x[w[19:15]] + x[w[24:20]];
            end
         end
         else if (w[6:0] == 7'h23) begin
            sImm = {{20{w[31]}}, w[31:25], w[11:7]};
            expWEn.push_back(1'b1);
            expAddr.push_back(x[w[19:15]] + sImm);
            expData.push_back(x[w[24:20]]);
         end
      end
   endfunction

   task automatic failTest(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "test stopped");
   endtask

   task automatic checkFetchAddr(input word_t got, input word_t exp);
      if (got !== exp) begin
         failTest($sformatf("MISMATCH addr (fetch): got 0x%h, expected 0x%h", got, exp));
      end
   endtask

   task automatic checkStoreAddr(input word_t got, input word_t exp);
      if (got !== exp) begin
         failTest($sformatf("MISMATCH addr (store): got 0x%h, expected 0x%h", got, exp));
      end
   endtask

   task automatic checkStoreData(input word_t got, input word_t exp);
      if (got !== exp) begin
         failTest($sformatf("MISMATCH wData: got 0x%h, expected 0x%h", got, exp));
      end
   endtask

   task automatic waitTransfer();
      int cycles;
      cycles = 0;
      while (obsAddr.size() == 0) begin
         @(negedge clk);
         cycles++;
         if (cycles > timeoutCycles) begin
            failTest($sformatf("no transfer arrived on the memory port within %0d cycles",
                               timeoutCycles));
         end
      end
   endtask

   // answers each transfer after 0 to maxDelay extra cycles
   initial begin : memoryModel
      int unsigned remaining;
      logic busy;
      busy = 1'b0;
      remaining = 0;
      forever begin
         @(posedge clk);
         if (!rstn) begin
            vld <= 1'b0;
            busy = 1'b0;
         end
         else if (vld && rdy) begin
            vld <= 1'b0;
            busy = 1'b0;
            obsWEn.push_back(wEn);
            obsAddr.push_back(addr);
            obsData.push_back(wData);
         end
         else if (rdy) begin
            if (!busy) begin
               busy = 1'b1;
               remaining = $unsigned($random(seed)) % (maxDelay + 1);
            end
            if (remaining == 0) begin
               vld <= 1'b1;
               rData <= wEn ? '0 : fetchWord(addr);
            end
            else begin
               remaining--;
            end
         end
      end
   end

   initial begin
      logic  gotWEn;
      word_t gotAddr;
      word_t gotData;
      rstn = 1'b0;
      run = 1'b1;
      rData = '0;
      vld = 1'b0;
      seed = 54;

      prog[0]  = encodeLui(5'd1, 20'h12345);
      prog[1]  = encodeSw(5'd1, 5'd0, 12'h040);
      prog[2]  = encodeLui(5'd2, 20'h00001);
      prog[3]  = encodeLui(5'd3, 20'hABCDE);
      prog[4]  = encodeAdd(5'd4, 5'd2, 5'd3);
      // negative offset from x2
      prog[5]  = encodeSw(5'd4, 5'd2, 12'hFFC);
      prog[6]  = encodeLui(5'd0, 20'h77777);
      prog[7]  = encodeAdd(5'd0, 5'd1, 5'd2);
      prog[8]  = encodeSw(5'd0, 5'd2, 12'h008);
      // addi x1, x0, 5 is outside the decoded set
      prog[9]  = 32'h0050_0093;
      prog[10] = encodeAdd(5'd1, 5'd2, 5'd3) | 32'h4000_0000;
      prog[11] = encodeAdd(5'd1, 5'd2, 5'd3) | 32'h0000_1000;
      prog[12] = encodeSw(5'd1, 5'd2, 12'h000);
      prog[13] = encodeSw(5'd4, 5'd3, 12'h800);
      prog[14] = encodeLui(5'd5, 20'hFFFFF);
      prog[15] = encodeSw(5'd3, 5'd4, 12'h001);
      refModel();

      repeat (5) @(posedge clk);
      rstn <= 1'b1;

      while (expAddr.size() > 0) begin
         waitTransfer();
         gotWEn = obsWEn.pop_front();
         gotAddr = obsAddr.pop_front();
         gotData = obsData.pop_front();
         if (gotWEn !== expWEn[0]) begin
            failTest($sformatf("MISMATCH wEn: got 0x%h, expected 0x%h at addr 0x%h",
                               gotWEn, expWEn[0], gotAddr));
         end
         if (expWEn[0]) begin
            checkStoreAddr(gotAddr, expAddr[0]);
            checkStoreData(gotData, expData[0]);
         end
         else begin
            checkFetchAddr(gotAddr, expAddr[0]);
         end
         void'(expWEn.pop_front());
         void'(expAddr.pop_front());
         void'(expData.pop_front());
      end

      $display("** PASS **");
      $finish;
   end

endmodule
